/* design/mha_sa_params.svh */
`ifndef MHA_SA_PARAMS_SVH
`define MHA_SA_PARAMS_SVH

////////////////////
// Array sizing
////////////////////

// Data word width, Q2.5 signed
// Rounding taps in sa_pe assume 8 bits
`define SA_D_W 8

// Grid is SA_N by SA_N PEs
`define SA_N 4

// Row index width, log2 of SA_N
`define SA_IDX_W 2

`endif

/* design/mha_sa_pkg.sv */
`include "mha_sa_params.svh"

package mha_sa_pkg;

    ////////////////////
    // Link and vector types
    ////////////////////

    // One x or w hop between neighbor PEs
    typedef struct packed {
        logic               vld;
        logic [`SA_D_W-1:0] data;
    } sa_link_t;

    // SA_N data words, element i is lane i
    typedef logic [`SA_N-1:0][`SA_D_W-1:0] sa_vec_t;

    // One row of the finished tile
    typedef struct packed {
        logic [`SA_IDX_W-1:0] idx;
        sa_vec_t              row;
    } sa_res_row_t;

    ////////////////////
    // Product decode
    ////////////////////

    // Q5.10 product split for rounding back to Q2.5
    typedef struct packed {
        // Bit 15
        logic       sign;
        // Bits 14..12, dropped without saturation
        logic [2:0] drop_int;
        // Bits 11..5, low seven bits of the Q2.5 result
        logic [6:0] kept;
        // Bit 4, half LSB of the result
        logic       rnd;
        // Bits 3..0
        logic [3:0] frac;
    } fxp_prod_fields_t;

    // Multiplier writes raw, rounding reads fields
    typedef union packed {
        logic [2*`SA_D_W-1:0] raw;
        fxp_prod_fields_t     f;
    } fxp_prod_u;

endpackage

/* design/sa_pe.sv */
`timescale 1ns/1ps
`include "mha_sa_params.svh"

module sa_pe (
    input  logic                 I_CLK,
    input  logic                 I_ASYN_RSTN,
    input  logic                 clr,
    input  mha_sa_pkg::sa_link_t x_in,
    input  mha_sa_pkg::sa_link_t w_in,
    output mha_sa_pkg::sa_link_t x_out,
    output mha_sa_pkg::sa_link_t w_out,
    output logic [`SA_D_W-1:0]   acc
);
    import mha_sa_pkg::*;

    // Full precision product
    fxp_prod_u          prod;
    // Product rounded to Q2.5
    logic [`SA_D_W-1:0] prod_rnd;

    ////////////////////
    // Multiply and round
    ////////////////////

    always_comb begin
        // Signed 8x8 into 16 bits
        prod.raw = $signed(x_in.data) * $signed(w_in.data);
        // Keep sign plus bits 11..5
        // Round half up on bit 4
        prod_rnd = {prod.f.sign, prod.f.kept} + {{(`SA_D_W-1){1'b0}}, prod.f.rnd};
    end

    ////////////////////
    // Accumulate and forward
    ////////////////////

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            x_out <= '0;
            w_out <= '0;
            acc   <= '0;
        end else if (clr) begin
            // New tile
            x_out <= '0;
            w_out <= '0;
            acc   <= '0;
        end else if (x_in.vld) begin
            // Pass x right
            x_out.vld  <= 1'b1;
            x_out.data <= x_in.data;
            // Pass w down
            w_out.vld  <= 1'b1;
            w_out.data <= w_in.data;
            // Wraps modulo 256
            acc        <= acc + prod_rnd;
        end else begin
            // Hold data, drop valid
            x_out.vld <= 1'b0;
            w_out.vld <= 1'b0;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Skew stage and upstream PEs keep x and w in step
    // A mismatch means the diagonal wavefront is broken
    a_xw_aligned : assert property (
        @(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        x_in.vld == w_in.vld
    ) else $error("sa_pe x and w valid not aligned");

endmodule

/* design/sa_input_skew.sv */
`timescale 1ns/1ps
`include "mha_sa_params.svh"

module sa_input_skew (
    input  logic                 I_CLK,
    input  logic                 I_ASYN_RSTN,
    input  logic                 clr,
    input  logic                 in_vld,
    input  mha_sa_pkg::sa_vec_t  in_x_vec,
    input  mha_sa_pkg::sa_vec_t  in_w_vec,
    output mha_sa_pkg::sa_link_t x_edge [`SA_N],
    output mha_sa_pkg::sa_link_t w_edge [`SA_N]
);
    import mha_sa_pkg::*;

    genvar i;

    ////////////////////
    // Triangular delay lines
    ////////////////////

    // Lane i gets i+1 stages
    // Lane 0 feeds PE (0,0) first, lane SA_N-1 last
    generate
        for (i = 0; i < `SA_N; i++) begin : g_lane
            // Row i of A
            sa_link_t x_dly [i+1];
            // Column i of B
            sa_link_t w_dly [i+1];

            always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
                if (!I_ASYN_RSTN) begin
                    for (int k = 0; k <= i; k++) begin
                        x_dly[k] <= '0;
                        w_dly[k] <= '0;
                    end
                end else if (clr) begin
                    // Flush anything left from the previous tile
                    for (int k = 0; k <= i; k++) begin
                        x_dly[k] <= '0;
                        w_dly[k] <= '0;
                    end
                end else begin
                    // First stage samples the port
                    x_dly[0] <= '{vld: in_vld, data: in_x_vec[i]};
                    w_dly[0] <= '{vld: in_vld, data: in_w_vec[i]};
                    // Valid rides with data down the line
                    for (int k = 1; k <= i; k++) begin
                        x_dly[k] <= x_dly[k-1];
                        w_dly[k] <= w_dly[k-1];
                    end
                end
            end

            // Last stage drives the grid edge
            assign x_edge[i] = x_dly[i];
            assign w_edge[i] = w_dly[i];
        end
    endgenerate

    ////////////////////
    // Checks
    ////////////////////

    // Clear must come before the tile, never during a step
    a_no_vld_on_clr : assert property (
        @(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        !(in_vld && clr)
    ) else $error("sa_input_skew in_vld high during clr");

endmodule

/* design/sa_pe_grid.sv */
`timescale 1ns/1ps
`include "mha_sa_params.svh"

module sa_pe_grid (
    input  logic                 I_CLK,
    input  logic                 I_ASYN_RSTN,
    input  logic                 clr,
    input  mha_sa_pkg::sa_link_t x_edge   [`SA_N],
    input  mha_sa_pkg::sa_link_t w_edge   [`SA_N],
    output mha_sa_pkg::sa_vec_t  acc_rows [`SA_N]
);
    import mha_sa_pkg::*;

    // Horizontal links, column SA_N is the right edge
    sa_link_t x_link [`SA_N][`SA_N+1];
    // Vertical links, row SA_N is the bottom edge
    sa_link_t w_link [`SA_N+1][`SA_N];

    genvar r;
    genvar c;

    ////////////////////
    // Edge feeds
    ////////////////////

    generate
        // Left edge from skewed A rows
        for (r = 0; r < `SA_N; r++) begin : g_left
            assign x_link[r][0] = x_edge[r];
        end

        // Top edge from skewed B columns
        for (c = 0; c < `SA_N; c++) begin : g_top
            assign w_link[0][c] = w_edge[c];
        end
    endgenerate

    ////////////////////
    // PE array
    ////////////////////

    // x moves right, w moves down
    // Right and bottom edge links end here
    generate
        for (r = 0; r < `SA_N; r++) begin : g_row
            for (c = 0; c < `SA_N; c++) begin : g_col
                sa_pe u_pe (
                    .I_CLK       (I_CLK),
                    .I_ASYN_RSTN (I_ASYN_RSTN),
                    .clr         (clr),
                    .x_in        (x_link[r][c]),
                    .w_in        (w_link[r][c]),
                    .x_out       (x_link[r][c+1]),
                    .w_out       (w_link[r+1][c]),
                    // Element (r,c) of the result tile
                    .acc         (acc_rows[r][c])
                );
            end
        end
    endgenerate

endmodule

/* design/sa_result_drain.sv */
`timescale 1ns/1ps
`include "mha_sa_params.svh"

module sa_result_drain (
    input  logic                    I_CLK,
    input  logic                    I_ASYN_RSTN,
    input  logic                    clr,
    input  logic                    in_vld,
    input  logic                    in_last,
    input  mha_sa_pkg::sa_vec_t     acc_rows [`SA_N],
    output logic                    res_vld,
    output mha_sa_pkg::sa_res_row_t res_row
);
    import mha_sa_pkg::*;

    // Skew plus grid depth, last PE done one edge before
    localparam int unsigned lat_d    = 2 * `SA_N;
    localparam int unsigned last_row = `SA_N - 1;

    // Accepted final step
    logic                 last_acc;
    // Last strobe in flight through skew and grid
    logic [lat_d-1:0]     last_sr;
    // Snapshot taken this edge
    logic                 snap_en;
    // Rows still to send
    logic                 busy;
    logic [`SA_IDX_W-1:0] row_cnt;
    // Frozen copy of the tile
    sa_vec_t              snap [`SA_N];

    assign last_acc = in_vld & in_last;
    assign snap_en  = last_sr[lat_d-1];

    ////////////////////
    // Latency tracker
    ////////////////////

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            last_sr <= '0;
        end else if (clr) begin
            last_sr <= '0;
        end else begin
            last_sr <= {last_sr[lat_d-2:0], last_acc};
        end
    end

    ////////////////////
    // Tile snapshot
    ////////////////////

    // Grid is free for the next tile after this
    always_ff @(posedge I_CLK) begin
        if (snap_en) begin
            snap <= acc_rows;
        end
    end

    ////////////////////
    // Row sequencer
    ////////////////////

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            busy    <= 1'b0;
            row_cnt <= '0;
        end else if (clr) begin
            busy    <= 1'b0;
            row_cnt <= '0;
        end else if (snap_en) begin
            // Start at row 0
            busy    <= 1'b1;
            row_cnt <= '0;
        end else if (busy) begin
            row_cnt <= row_cnt + 1'b1;
            // Stop after the bottom row
            if (row_cnt == last_row[`SA_IDX_W-1:0]) begin
                busy <= 1'b0;
            end
        end
    end

    // One row per cycle, no stall
    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            res_vld <= 1'b0;
        end else if (clr) begin
            res_vld <= 1'b0;
        end else begin
            res_vld <= busy;
        end
    end

    always_ff @(posedge I_CLK) begin
        if (busy) begin
            res_row <= '{idx: row_cnt, row: snap[row_cnt]};
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Only one tile in flight, the snapshot would be overwritten
    a_one_tile : assert property (
        @(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        last_acc |-> ((last_sr == '0) && !busy)
    ) else $error("sa_result_drain new last while tile in flight");

endmodule

/* design/mha_sa_top.sv */
`timescale 1ns/1ps
`include "mha_sa_params.svh"

module mha_sa_top (
    input  logic                    I_CLK,
    input  logic                    I_ASYN_RSTN,
    input  logic                    clr,
    input  logic                    in_vld,
    input  logic                    in_last,
    input  mha_sa_pkg::sa_vec_t     in_x_vec,
    input  mha_sa_pkg::sa_vec_t     in_w_vec,
    output logic                    res_vld,
    output mha_sa_pkg::sa_res_row_t res_row
);
    import mha_sa_pkg::*;

    // Skewed edge links
    sa_link_t x_edge   [`SA_N];
    sa_link_t w_edge   [`SA_N];
    // Live accumulators
    sa_vec_t  acc_rows [`SA_N];

    ////////////////////
    // Stage 1, skew
    ////////////////////

    sa_input_skew u_skew (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .clr         (clr),
        .in_vld      (in_vld),
        .in_x_vec    (in_x_vec),
        .in_w_vec    (in_w_vec),
        .x_edge      (x_edge),
        .w_edge      (w_edge)
    );

    ////////////////////
    // Stage 2, PE grid
    ////////////////////

    sa_pe_grid u_grid (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .clr         (clr),
        .x_edge      (x_edge),
        .w_edge      (w_edge),
        .acc_rows    (acc_rows)
    );

    ////////////////////
    // Stage 3, drain
    ////////////////////

    // Strobes come straight from the ports
    sa_result_drain u_drain (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .clr         (clr),
        .in_vld      (in_vld),
        .in_last     (in_last),
        .acc_rows    (acc_rows),
        .res_vld     (res_vld),
        .res_row     (res_row)
    );

endmodule

/* tb/tb_mha_sa.sv */
`timescale 1ns/1ps
`include "mha_sa_params.svh"

module tb_mha_sa;
    import mha_sa_pkg::*;

    localparam int NUM_CASES = 6;
    localparam int MAX_K     = 2 * `SA_N;
    // Edges from accepted last step to first row
    localparam int LAT_EXP   = 2 * `SA_N + 1;
    localparam int WAIT_MAX  = 4 * `SA_N + 8;

    logic        I_CLK;
    logic        I_ASYN_RSTN;
    logic        clr;
    logic        in_vld;
    logic        in_last;
    sa_vec_t     in_x_vec;
    sa_vec_t     in_w_vec;
    logic        res_vld;
    sa_res_row_t res_row;

    ////////////////////
    // Test table
    ////////////////////

    string   case_name [NUM_CASES];
    int      case_k    [NUM_CASES];
    bit      case_rand [NUM_CASES];
    // A row r, element k is step k
    sa_vec_t tab_a     [NUM_CASES][`SA_N];
    // B row k, element j is column j
    sa_vec_t tab_b     [NUM_CASES][`SA_N];

    // Tile under test and model result
    logic [`SA_D_W-1:0] a_mat [`SA_N][MAX_K];
    logic [`SA_D_W-1:0] b_mat [MAX_K][`SA_N];
    logic [`SA_D_W-1:0] c_exp [`SA_N][`SA_N];

    int n_checks;
    int n_errors;
    int n_tests_ok;
    int n_tests_bad;

    mha_sa_top u_mha_sa_top (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .clr         (clr),
        .in_vld      (in_vld),
        .in_last     (in_last),
        .in_x_vec    (in_x_vec),
        .in_w_vec    (in_w_vec),
        .res_vld     (res_vld),
        .res_row     (res_row)
    );

    initial begin
        I_CLK = 1'b0;
        forever #50 I_CLK = ~I_CLK;
    end

    task automatic set_case(input int t, input string name, input int k, input bit rnd);
        case_name[t] = name;
        case_k[t]    = k;
        case_rand[t] = rnd;
    endtask

    task automatic build_table();
        // Q2.5 one is 0x20, so C equals B
        set_case(0, "identity_times_b", `SA_N, 1'b0);
        tab_a[0] = '{32'h0000_0020, 32'h0000_2000, 32'h0020_0000, 32'h2000_0000};
        tab_b[0] = '{32'h0403_0201, 32'h0807_0605, 32'hFCFD_FEFF, 32'h0C0B_0A09};
        // Products sitting on the half LSB, both signs
        set_case(1, "round_half_up", `SA_N, 1'b0);
        tab_a[1] = '{32'h0101_0101, 32'hFFFF_FFFF, 32'h0303_0303, 32'hFDFD_FDFD};
        tab_b[1] = '{32'hD0F0_3010, 32'hD0F0_3010, 32'h3010_D0F0, 32'h0000_0000};
        set_case(2, "random_k_n", `SA_N, 1'b1);
        set_case(3, "random_k_2n", MAX_K, 1'b1);
        // Full scale operands, sums wrap
        set_case(4, "wrap_full_scale", `SA_N, 1'b0);
        tab_a[4] = '{32'h7F7F_7F7F, 32'h8080_8080, 32'h7F80_7F80, 32'h807F_807F};
        tab_b[4] = '{32'h7F7F_7F7F, 32'h7F80_7F80, 32'h7F7F_8080, 32'h7F7F_7F7F};
        set_case(5, "back_to_back_k_2n", MAX_K, 1'b1);
    endtask

    task automatic load_case(input int t);
        logic [31:0] rnd;
        for (int i = 0; i < `SA_N; i++) begin
            for (int k = 0; k < MAX_K; k++) begin
                if (case_rand[t]) begin
                    rnd         = $urandom;
                    a_mat[i][k] = rnd[`SA_D_W-1:0];
                    b_mat[k][i] = rnd[2*`SA_D_W-1:`SA_D_W];
                end else if (k < `SA_N) begin
                    a_mat[i][k] = tab_a[t][i][k];
                    b_mat[k][i] = tab_b[t][k][i];
                end else begin
                    a_mat[i][k] = '0;
                    b_mat[k][i] = '0;
                end
            end
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Sign, bits 11..5, plus one when bit 4 set
    function automatic logic [`SA_D_W-1:0] round_prod(input logic [`SA_D_W-1:0] a,
                                                      input logic [`SA_D_W-1:0] b);
        logic signed [15:0] p;
        p = $signed(a) * $signed(b);
        return {p[15], p[11:5]} + {7'd0, p[4]};
    endfunction

    task automatic compute_expected(input int k_steps);
        logic [`SA_D_W-1:0] acc;
        for (int r = 0; r < `SA_N; r++) begin
            for (int c = 0; c < `SA_N; c++) begin
                acc = '0;
                // Wraps modulo 256 at every add
                for (int k = 0; k < k_steps; k++) begin
                    acc = acc + round_prod(a_mat[r][k], b_mat[k][c]);
                end
                c_exp[r][c] = acc;
            end
        end
    endtask

    ////////////////////
    // Drive and check
    ////////////////////

    task automatic pulse_clr();
        @(posedge I_CLK);
        clr <= 1'b1;
        @(posedge I_CLK);
        clr <= 1'b0;
    endtask

    task automatic drive_tile(input int k_steps);
        for (int k = 0; k < k_steps; k++) begin
            @(posedge I_CLK);
            in_vld  <= 1'b1;
            in_last <= (k == k_steps - 1);
            for (int i = 0; i < `SA_N; i++) begin
                in_x_vec[i] <= a_mat[i][k];
                in_w_vec[i] <= b_mat[k][i];
            end
            // No row while the tile is loading
            @(negedge I_CLK);
            check_eq(int'(res_vld), 0, $sformatf("res_vld at step %0d", k));
        end
        // Edge that accepts the final step
        @(posedge I_CLK);
        in_vld  <= 1'b0;
        in_last <= 1'b0;
    endtask

    task automatic check_eq(input int got, input int want, input string what);
        n_checks++;
        assert (got == want) else begin
            $display("FAILED %0t ns: %s got %0h expected %0h", $time, what, got, want);
            n_errors++;
        end
    endtask

    task automatic collect_rows(input string name);
        int n;
        bit seen;
        seen = 1'b0;
        n    = 0;
        // Outputs sampled on the falling edge
        while (!seen && n < WAIT_MAX) begin
            @(negedge I_CLK);
            if (res_vld) seen = 1'b1;
            else n++;
        end
        if (!seen) begin
            $display("Timeout: no result row within %0d cycles in %s", WAIT_MAX, name);
            n_errors++;
        end else begin
            check_eq(n, LAT_EXP, {name, " latency"});
            for (int r = 0; r < `SA_N; r++) begin
                // Rows on consecutive cycles
                if (r > 0) begin
                    @(negedge I_CLK);
                    check_eq(int'(res_vld), 1, $sformatf("%s res_vld row %0d", name, r));
                end
                check_eq(int'(res_row.idx), r, $sformatf("%s row index", name));
                for (int c = 0; c < `SA_N; c++) begin
                    check_eq(int'(res_row.row[c]), int'(c_exp[r][c]),
                             $sformatf("%s C[%0d][%0d]", name, r, c));
                end
            end
            @(negedge I_CLK);
            check_eq(int'(res_vld), 0, {name, " res_vld after last row"});
        end
    endtask

    task automatic check_idle(input string where);
        @(negedge I_CLK);
        check_eq(int'(res_vld), 0, {"res_vld ", where});
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int errs_before;
        I_ASYN_RSTN = 1'b0;
        clr         = 1'b0;
        in_vld      = 1'b0;
        in_last     = 1'b0;
        in_x_vec    = '0;
        in_w_vec    = '0;
        n_checks    = 0;
        n_errors    = 0;
        n_tests_ok  = 0;
        n_tests_bad = 0;
        void'($urandom(32'h2bfc3105));
        build_table();

        repeat (8) @(posedge I_CLK);
        I_ASYN_RSTN <= 1'b1;
        check_idle("after reset");

        // Tiles back to back, only clr between them
        for (int t = 0; t < NUM_CASES; t++) begin
            errs_before = n_errors;
            check_idle({"before ", case_name[t]});
            load_case(t);
            compute_expected(case_k[t]);
            pulse_clr();
            drive_tile(case_k[t]);
            collect_rows(case_name[t]);
            if (n_errors == errs_before) begin
                n_tests_ok++;
                $display("Test %s: ok", case_name[t]);
            end else begin
                n_tests_bad++;
                $display("Test %s: %0d errors", case_name[t], n_errors - errs_before);
            end
        end

        $display("Tests %0d ok, %0d bad, %0d checks, %0d errors",
                 n_tests_ok, n_tests_bad, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* mha_sa.f */
+incdir+design
design/mha_sa_pkg.sv
design/sa_pe.sv
design/sa_input_skew.sv
design/sa_pe_grid.sv
design/sa_result_drain.sv
design/mha_sa_top.sv
tb/tb_mha_sa.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_mha_sa \
    -f mha_sa.f -o sim_mha_sa \
    && ./obj_dir/sim_mha_sa > sim.log 2>&1 \
    || { echo "Build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
